// File: src/fmaAdd_consts.svh
/*
  Field widths and pipeline depth for the half-precision addition stage.
  Subnormals, infinities and NaN are not encoded by these fields.
*/
`ifndef FMA_ADD_CONSTS_SVH
`define FMA_ADD_CONSTS_SVH

// biased exponent field of a half word
`define FMA_EXP_W 5

// stored fraction, hidden one excluded
`define FMA_FRAC_W 10

// significand with the hidden one
`define FMA_SIG_W 11

// carry bit + significand + guard bits below it
`define FMA_SUM_W 23

// leading-zero count over the 22 bits under the carry
`define FMA_LZC_W 5

// cycles from inValid to outValid
`define FMA_LATENCY 2

`endif

// File: src/fmaAddPkg.sv
/*
  Shared field types of the half-precision addition datapath.
  Widths come from the consts header and are fixed to half precision.
*/
`include "fmaAdd_consts.svh"

package fmaAddPkg;

    // sign, exponent, fraction
    typedef logic [`FMA_EXP_W + `FMA_FRAC_W:0] halfT;

    // biased exponent, range 1..30 is the only one handled
    typedef logic [`FMA_EXP_W-1:0] expT;

    // significand with hidden one on top
    typedef logic [`FMA_SIG_W-1:0] sigT;

    // aligned sum magnitude
    // bit 22 is the carry, bits 21..11 the significand, 10..0 guard
    typedef logic [`FMA_SUM_W-1:0] sumT;

    // zeros above the leading one
    typedef logic [`FMA_LZC_W-1:0] lzcT;

endpackage

// File: src/sumIf.sv
/*
  Stage-1 to stage-2 bus of the adder pipeline. Plain valid strobe only,
  no handshake. Data fields are meaningful only while valid is high.
*/
`include "fmaAdd_consts.svh"

interface sumIf;
    import fmaAddPkg::*;

    // item present in stage 1 register
    logic valid;
    // sign of the operand with the larger magnitude
    logic sign;
    // exponent of the larger operand
    expT bigExp;
    // unsigned sum or difference of the aligned significands
    sumT mag;
    // exponent gap of 11 or more, larger operand wins outright
    logic passThru;
    // larger operand with its final sign
    halfT passWord;

    // stage 1 side
    modport src (output valid, sign, bigExp, mag, passThru, passWord);

    // stage 2 side
    modport dst (input valid, sign, bigExp, mag, passThru, passWord);

endinterface

// File: src/alignAddStage.sv
/*
  First pipeline stage. Orders product and addend by magnitude, aligns and
  adds or subtracts the significands, registers the result one cycle later.
  Inputs must be normal numbers. negz flips only the sign bit of z.
*/
`include "fmaAdd_consts.svh"

module alignAddStage (
    input  logic            clk,
    input  logic            rstN,
    input  logic            inValid,
    input  fmaAddPkg::halfT product,
    input  fmaAddPkg::halfT z,
    input  logic            negz,
    sumIf.src               sumOut
);
    import fmaAddPkg::*;

    // sign position inside a half word
    localparam int signPos = `FMA_EXP_W + `FMA_FRAC_W;

    // addend after the negz sign flip
    halfT zEff;

    // product is at least as large as the addend
    logic pBig;
    halfT bigWord;
    halfT smallWord;

    expT bigExp;
    expT smallExp;
    expT expDiff;

    sigT bigSig;
    sigT smallSig;

    // smaller significand pushed into the guard bits
    logic [2*`FMA_SIG_W-1:0] smallAligned;

    sumT bigExt;
    sumT smallExt;
    sumT magNext;

    logic effSub;
    logic dominant;

    // negation is a sign flip, never a two's complement of the word
    assign zEff = {z[signPos] ^ negz, z[signPos-1:0]};

    // exponent sits above the fraction
    // so comparing the low 15 bits orders the magnitudes
    assign pBig = product[signPos-1:0] >= zEff[signPos-1:0];

    assign bigWord   = pBig ? product : zEff;
    assign smallWord = pBig ? zEff : product;

    // unpack the exponents
    assign bigExp   = bigWord[signPos-1:`FMA_FRAC_W];
    assign smallExp = smallWord[signPos-1:`FMA_FRAC_W];

    // never negative, bigWord has the larger exponent
    assign expDiff = bigExp - smallExp;

    // gap at or beyond the significand width
    // smaller operand cannot reach the truncated fraction
    assign dominant = expDiff >= expT'(`FMA_SIG_W);

    // restore hidden ones
    assign bigSig   = {1'b1, bigWord[`FMA_FRAC_W-1:0]};
    assign smallSig = {1'b1, smallWord[`FMA_FRAC_W-1:0]};

    // align the smaller significand below the larger one
    // bits shifted past the guard field only matter when dominant
    assign smallAligned = {smallSig, {`FMA_SIG_W{1'b0}}} >> expDiff;

    // zero carry bit on top of both
    assign bigExt   = {1'b0, bigSig, {`FMA_SIG_W{1'b0}}};
    assign smallExt = {1'b0, smallAligned};

    // unlike signs mean a true subtraction
    assign effSub = bigWord[signPos] ^ smallWord[signPos];

    // big >= small, so the difference never wraps
    assign magNext = effSub ? (bigExt - smallExt) : (bigExt + smallExt);

    // valid strobe, one cycle behind inValid
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            sumOut.valid <= 1'b0;
        end else begin
            sumOut.valid <= inValid;
        end
    end

    // payload only loads with an item
    always_ff @(posedge clk) begin
        if (inValid) begin
            // result sign follows the larger magnitude
            sumOut.sign     <= bigWord[signPos];
            sumOut.bigExp   <= bigExp;
            sumOut.mag      <= magNext;
            sumOut.passThru <= dominant;
            // already carries the flipped sign when z is larger
            sumOut.passWord <= bigWord;
        end
    end

endmodule

// File: src/leadingZeroCount.sv
/*
  Leading-zero count over the 22 bits below the carry of the sum magnitude.
  Result is meaningful only with the carry clear and a nonzero magnitude.
*/
module leadingZeroCount (
    input  fmaAddPkg::sumT mag,
    output fmaAddPkg::lzcT count
);
    import fmaAddPkg::*;

    // bits searched, carry bit excluded
    localparam int spanW = $bits(sumT) - 1;

    // scan upward so the highest set bit is the last one to write
    always_comb begin
        // all-zero span gives the full width
        count = lzcT'(spanW);
        for (int i = 0; i < spanW; i++) begin
            if (mag[i]) begin
                // zeros between bit i and the top of the span
                count = lzcT'(spanW - 1 - i);
            end
        end
    end

endmodule

// File: src/normalizeStage.sv
/*
  Second pipeline stage. Normalizes the aligned sum, truncates the fraction
  and registers the packed half word one cycle after sumIn.valid.
  No rounding, and exponent overflow or underflow is not detected.
*/
`include "fmaAdd_consts.svh"

module normalizeStage (
    input  logic            clk,
    input  logic            rstN,
    sumIf.dst               sumIn,
    output logic            outValid,
    output fmaAddPkg::halfT sum
);
    import fmaAddPkg::*;

    // carry bit of the magnitude
    localparam int carryPos = `FMA_SUM_W - 1;

    lzcT zeroCount;
    sumT shifted;

    logic carry;
    logic isZero;

    expT expNext;
    logic [`FMA_FRAC_W-1:0] fracNext;
    halfT sumNext;

    leadingZeroCount lzc (
        .mag   (sumIn.mag),
        .count (zeroCount)
    );

    assign carry  = sumIn.mag[carryPos];
    assign isZero = sumIn.mag == '0;

    // moves the leading one up to bit 21
    assign shifted = sumIn.mag << zeroCount;

    always_comb begin
        if (carry) begin
            // leading one in the carry bit
            // fraction is the ten bits right under it
            fracNext = sumIn.mag[carryPos-1 -: `FMA_FRAC_W];
            expNext  = sumIn.bigExp + 1'b1;
        end else begin
            // hidden one at bit 21 after the shift
            fracNext = shifted[carryPos-2 -: `FMA_FRAC_W];
            expNext  = sumIn.bigExp - expT'(zeroCount);
        end

        // dominance first, then exact cancellation
        if (sumIn.passThru) begin
            sumNext = sumIn.passWord;
        end else if (isZero) begin
            // always positive zero
            sumNext = '0;
        end else begin
            sumNext = {sumIn.sign, expNext, fracNext};
        end
    end

    // output strobe follows the stage-1 strobe
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else begin
            outValid <= sumIn.valid;
        end
    end

    // result word holds until the next item
    always_ff @(posedge clk) begin
        if (sumIn.valid) begin
            sum <= sumNext;
        end
    end

endmodule

// File: src/fmaAddTop.sv
/*
  Addition stage of a half-precision FMA, two cycles from inValid to outValid.
  One item per cycle, no back-pressure. Normal operands only, and results
  with an exponent outside 1..30 are undefined.
*/
module fmaAddTop (
    input  logic            clk,
    input  logic            rstN,
    input  logic            inValid,
    input  fmaAddPkg::halfT product,
    input  fmaAddPkg::halfT z,
    input  logic            negz,
    output logic            outValid,
    output fmaAddPkg::halfT sum
);

    // aligned sum between the two stages
    sumIf stageBus ();

    // unpack, order, align, add or subtract
    alignAddStage alignAdd (
        .clk     (clk),
        .rstN    (rstN),
        .inValid (inValid),
        .product (product),
        .z       (z),
        .negz    (negz),
        .sumOut  (stageBus.src)
    );

    // normalize, truncate, pack
    normalizeStage normalize (
        .clk      (clk),
        .rstN     (rstN),
        .sumIn    (stageBus.dst),
        .outValid (outValid),
        .sum      (sum)
    );

endmodule

// File: verif/fmaAdd_chk.sv
/*
  Protocol checks on the addition pipeline, bound into fmaAddTop.
  Expects inValid low while rstN is low.
*/
`include "fmaAdd_consts.svh"

module fmaAddChk (
    input logic            clk,
    input logic            rstN,
    input logic            inValid,
    input logic            outValid,
    input fmaAddPkg::halfT sum
);

    // strobe held low through reset
    outLowInReset: assert property (@(posedge clk) !rstN |-> !outValid)
        else $error("outValid high while reset is asserted");

    // no stale item on the first edge out of reset
    outLowAfterReset: assert property (@(posedge clk) $rose(rstN) |-> !outValid)
        else $error("outValid high right after reset release");

    // fixed latency, nothing dropped and nothing invented
    latencyMatch: assert property (@(posedge clk) disable iff (!rstN)
        outValid == $past(inValid, `FMA_LATENCY))
        else $error("outValid does not follow inValid by the pipeline latency");

    // result word fully driven with its strobe
    sumKnown: assert property (@(posedge clk) disable iff (!rstN)
        outValid |-> !$isunknown(sum))
        else $error("sum has unknown bits while outValid is high");

endmodule

// File: verif/fmaAddTb.sv
/*
  Testbench for the half-precision addition stage. Operands are normal
  numbers only, and any draw whose result exponent leaves 1..30 is redrawn.
  Expected words come from an exact integer model truncated toward zero.
*/
`include "fmaAdd_consts.svh"

module fmaAddTb;
    import fmaAddPkg::*;

    localparam int resetCycles = 8;
    localparam int numStream   = 1000;
    localparam int numGapped   = 1000;
    localparam int maxGap      = 3;
    // directed items plus their idle cycles stay below this
    localparam int dirBound    = 40;
    localparam int cycleLimit  = resetCycles + dirBound + numStream
                               + numGapped * (maxGap + 1) + 50;

    logic clk;
    logic rstN;
    logic inValid;
    halfT product;
    halfT z;
    logic negz;
    logic outValid;
    halfT sum;

    // expected words in issue order
    halfT expQ[$];
    halfT expWord;
    int   sent;
    int   checked;
    int   cycleCount;

    fmaAddTop uut (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (inValid),
        .product  (product),
        .z        (z),
        .negz     (negz),
        .outValid (outValid),
        .sum      (sum)
    );

    bind fmaAddTop fmaAddChk chk (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (inValid),
        .outValid (outValid),
        .sum      (sum)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // exact sum of two halves, magnitude truncated to ten fraction bits
    // operand value is significand << (exp - 1), so everything stays integral
    function automatic halfT refSum(input halfT p, input halfT zz, input logic nz,
                                    output logic outOfRange);
        logic       sp;
        logic       sz;
        int         ep;
        int         ez;
        longint     vp;
        longint     vz;
        longint     total;
        longint     mag;
        int         msb;
        int         rexp;
        logic [9:0] frac;
        sp = p[15];
        // negation flips the sign bit only
        sz = zz[15] ^ nz;
        ep = int'(p[14:10]);
        ez = int'(zz[14:10]);
        outOfRange = 1'b0;
        // larger operand wins outright past the significand width
        if (ep - ez >= 11) begin
            return p;
        end
        if (ez - ep >= 11) begin
            return {sz, zz[14:0]};
        end
        vp = longint'({1'b1, p[9:0]}) << (ep - 1);
        vz = longint'({1'b1, zz[9:0]}) << (ez - 1);
        if (sp) vp = -vp;
        if (sz) vz = -vz;
        total = vp + vz;
        mag = (total < 0) ? -total : total;
        // exact cancellation is positive zero
        if (mag == 0) begin
            return 16'h0000;
        end
        msb = 0;
        for (int i = 0; i < 48; i++) begin
            if (mag[i]) msb = i;
        end
        rexp = msb - 9;
        if (rexp < 1 || rexp > 30) outOfRange = 1'b1;
        if (msb >= 10) begin
            frac = 10'(mag >> (msb - 10));
        end else begin
            frac = 10'(mag << (10 - msb));
        end
        // sign of the exact sum is the sign of the larger magnitude
        return {total < 0, rexp[4:0], frac};
    endfunction

    // one item on the next rising edge, expected word queued with it
    task automatic sendItem(input halfT p, input halfT zz, input logic nz);
        halfT w;
        logic bad;
        w = refSum(p, zz, nz, bad);
        // result exponent outside 1..30 has no defined result
        assert (!bad) else begin
            $display("operands give a result exponent outside 1..30");
            $display("SIMULATION FAILED");
            $fatal(1, "operands out of range");
        end
        @(posedge clk);
        inValid <= 1'b1;
        product <= p;
        z       <= zz;
        negz    <= nz;
        expQ.push_back(w);
        sent++;
    endtask

    task automatic idleCycle();
        @(posedge clk);
        inValid <= 1'b0;
    endtask

    // random normal operands, half of them with close exponents
    task automatic randomItem();
        logic [31:0] r;
        int          ep;
        int          ez;
        halfT        p;
        halfT        zz;
        logic        nz;
        logic        bad;
        do begin
            r  = $urandom;
            ep = 1 + int'($urandom % 30);
            if (r[31]) begin
                // cancellation and dominance edges live here
                ez = ep + int'($urandom % 27) - 13;
            end else begin
                ez = 1 + int'($urandom % 30);
            end
            p   = {r[0], ep[4:0], r[10:1]};
            zz  = {r[11], ez[4:0], r[21:12]};
            nz  = r[22];
            bad = (ez < 1) || (ez > 30);
            if (!bad) begin
                void'(refSum(p, zz, nz, bad));
            end
        end while (bad);
        sendItem(p, zz, nz);
    endtask

    initial begin
        int gap;
        void'($urandom(32'hf6a7));
        rstN       = 1'b0;
        inValid    = 1'b0;
        product    = '0;
        z          = '0;
        negz       = 1'b0;
        sent       = 0;
        checked    = 0;
        cycleCount = 0;
        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;

        // like signs, equal exponents, carry out
        sendItem(16'h3C00, 16'h3C00, 1'b0);
        sendItem(16'h3E00, 16'h3E00, 1'b0);
        sendItem(16'hC7FF, 16'hC401, 1'b0);
        idleCycle();
        // unlike signs, deep cancellation, exact zero
        sendItem(16'h3C01, 16'hBC00, 1'b0);
        sendItem(16'h3FFF, 16'hBFFE, 1'b0);
        sendItem(16'h5A37, 16'hDA36, 1'b0);
        sendItem(16'h4000, 16'hC000, 1'b0);
        idleCycle();
        // same pairs with and without negz
        sendItem(16'h4100, 16'h3C80, 1'b0);
        sendItem(16'h4100, 16'h3C80, 1'b1);
        sendItem(16'h3C00, 16'h4200, 1'b0);
        sendItem(16'h3C00, 16'h4200, 1'b1);
        sendItem(16'hC500, 16'hC400, 1'b0);
        sendItem(16'hC500, 16'hC400, 1'b1);
        sendItem(16'h4000, 16'h4000, 1'b1);
        idleCycle();
        // gaps of 12 and 11 pass through, a gap of 10 still adds
        sendItem(16'h6000, 16'h3000, 1'b0);
        sendItem(16'h5C00, 16'hB3FF, 1'b0);
        sendItem(16'h3000, 16'h5C00, 1'b1);
        sendItem(16'h5800, 16'h3000, 1'b0);
        sendItem(16'h5BFF, 16'h33FF, 1'b1);
        idleCycle();

        // back to back
        repeat (numStream) randomItem();
        idleCycle();
        // random gaps between items
        repeat (numGapped) begin
            randomItem();
            gap = int'($urandom % (maxGap + 1));
            repeat (gap) idleCycle();
        end
        idleCycle();

        // drain the pipeline, the cycle counter bounds this wait
        while (expQ.size() != 0) @(posedge clk);
        // a stray result in these cycles finds the queue empty
        repeat (`FMA_LATENCY + 1) @(posedge clk);
        $display("SIMULATION PASSED");
        $finish;
    end

    // results are stable at the falling edge
    always @(negedge clk) begin
        if (rstN && outValid) begin
            assert (expQ.size() != 0) else begin
                $display("a result arrived with no input pending");
                $display("SIMULATION FAILED");
                $fatal(1, "unexpected output");
            end
            expWord = expQ.pop_front();
            assert (sum === expWord) else begin
                $display("** Error: sum = 0x%04h, expected 0x%04h (result %0d)",
                         sum, expWord, checked);
                $display("SIMULATION FAILED");
                $fatal(1, "sum mismatch");
            end
            checked++;
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("timeout after %0d cycles, %0d of %0d results checked",
                     cycleCount, checked, sent);
            $display("SIMULATION FAILED");
            $fatal(1, "run did not finish in time");
        end
    end

endmodule

// File: src.f
+incdir+src
src/fmaAddPkg.sv
src/sumIf.sv
src/alignAddStage.sv
src/leadingZeroCount.sv
src/normalizeStage.sv
src/fmaAddTop.sv
verif/fmaAdd_chk.sv
verif/fmaAddTb.sv

// File: Makefile
# Verilator build and run of the half-precision addition stage testbench
# override any variable on the command line, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= fmaAddTb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= SIMULATION PASSED
FAIL_MSG  ?= SIMULATION FAILED

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: help test build clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: build
	@$(SIM_BIN) > $(LOG) 2>&1; true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "test failed, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "test ended without a verdict, see $(LOG)"; exit 1; \
	else \
		echo "test passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
